/* hw/sad_pkg.sv */
`default_nettype none

package sad_pkg;

    localparam int REF_SAMPLES = 32;     // window length
    localparam int SAMPLE_BITS = 8;
    localparam int SAD_BITS = 16;        // msb doubles as saturation flag
    localparam int PHASE_BITS = 5;
    localparam int COUNT_BITS = 16;

    // last window sample at adc_datain to trigger high
    localparam int TRIGGER_LATENCY = 9;

    localparam int REF_BYTES = REF_SAMPLES * SAMPLE_BITS / 8;
    localparam int REFEN_BYTES = REF_SAMPLES / 8;
    localparam int SAD_BYTES = SAD_BITS / 8;

    // cycles from phase zero at the feed to the first increment of a window
    localparam int START_OFFSET = 3;

    typedef logic [SAMPLE_BITS-1:0] sample_t;
    typedef logic [SAD_BITS-1:0]    sad_t;
    typedef logic [PHASE_BITS-1:0]  phase_t;
    typedef logic [REF_SAMPLES-1:0] lane_vec_t;

    localparam phase_t LAST_PHASE = phase_t'(REF_SAMPLES - 1);
    localparam lane_vec_t LANE_START_INIT = lane_vec_t'(1) << (REF_SAMPLES - START_OFFSET);

endpackage

`default_nettype wire

/* hw/sad_regs_pkg.sv */
`default_nettype none

package sad_regs_pkg;

    localparam int BYTECNT_BITS = 7;
    localparam int REG_DATA_BITS = 8;

    // readback word widths, read out one byte at a time
    localparam int THRESHOLD_READ_BITS = 32;
    localparam int STATUS_BITS = 24;     // count, seven spare bits, triggered

    typedef logic [REG_DATA_BITS-1:0] reg_byte_t;

    typedef enum logic [7:0] {
        REG_REFERENCE         = 8'h00,
        REG_REFEN             = 8'h01,
        REG_THRESHOLD         = 8'h02,
        REG_STATUS            = 8'h03,  // any write clears it
        REG_MULTIPLE_TRIGGERS = 8'h04
    } sad_reg_addr_e;

endpackage

`default_nettype wire

/* hw/sad_cfg_if.sv */
`timescale 1ns/1ps
`default_nettype none

// host settings, static while a capture runs
interface sad_cfg_if import sad_pkg::*; ();

    sample_t [REF_SAMPLES-1:0] refsamples;
    lane_vec_t                 refen;      // per position compare enable
    sad_t                      threshold;
    logic                      multiple_triggers;

    modport host   (output refsamples, refen, threshold, multiple_triggers);
    modport seq    (input refsamples, refen);
    modport lanes  (input threshold);
    modport status (input multiple_triggers);

endinterface

`default_nettype wire

/* hw/sad_sched_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface sad_sched_if import sad_pkg::*; ();

    sample_t   feed_sample;  // reference for the current phase
    logic      feed_en;
    lane_vec_t lane_start;   // one hot, lane whose window restarts now
    lane_vec_t lane_ready;   // lanes holding a full window since arming

    modport sched (output feed_sample, feed_en, lane_start, lane_ready);
    modport lanes (input feed_sample, feed_en, lane_start, lane_ready);

endinterface

`default_nettype wire

/* hw/sad_reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module sad_reg_bank import sad_pkg::*, sad_regs_pkg::*; (
    input  logic                    adc_sampleclk,
    input  logic                    reset,
    input  sad_reg_addr_e           reg_address,
    input  logic [BYTECNT_BITS-1:0] reg_bytecnt,
    input  reg_byte_t               reg_datai,
    input  logic                    reg_read,
    input  logic                    reg_write,
    output reg_byte_t               reg_datao,
    input  logic                    triggered,
    input  logic [COUNT_BITS-1:0]   trigger_count,
    output logic                    clear_status,
    sad_cfg_if.host                 cfg
);

    logic [THRESHOLD_READ_BITS-1:0] threshold_word;
    logic [STATUS_BITS-1:0]         status_word;

    assign threshold_word = {{(THRESHOLD_READ_BITS - SAD_BITS){1'b0}}, cfg.threshold};
    assign status_word = {trigger_count, 7'b0, triggered};

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            cfg.refsamples <= '0;
            cfg.refen <= '1;                 // every position compared
            cfg.threshold <= '0;
            cfg.multiple_triggers <= 1'b0;
            clear_status <= 1'b0;
        end else begin
            clear_status <= reg_write && (reg_address == REG_STATUS);
            if (reg_write) begin
                case (reg_address)
                    REG_REFERENCE: begin
                        if (reg_bytecnt < REF_BYTES)
                            cfg.refsamples[reg_bytecnt[PHASE_BITS-1:0]] <= reg_datai;
                    end
                    REG_REFEN: begin
                        if (reg_bytecnt < REFEN_BYTES)
                            cfg.refen[reg_bytecnt*8 +: 8] <= reg_datai;
                    end
                    REG_THRESHOLD: begin
                        if (reg_bytecnt < SAD_BYTES)
                            cfg.threshold[reg_bytecnt*8 +: 8] <= reg_datai;
                    end
                    REG_MULTIPLE_TRIGGERS: cfg.multiple_triggers <= reg_datai[0];
                    default: ;
                endcase
            end
        end
    end

    // readback, zero outside the valid byte range
    always_comb begin
        reg_datao = '0;
        if (reg_read) begin
            case (reg_address)
                REG_REFERENCE: begin
                    if (reg_bytecnt < REF_BYTES)
                        reg_datao = cfg.refsamples[reg_bytecnt[PHASE_BITS-1:0]];
                end
                REG_REFEN: begin
                    if (reg_bytecnt < REFEN_BYTES)
                        reg_datao = cfg.refen[reg_bytecnt*8 +: 8];
                end
                REG_THRESHOLD: begin
                    if (reg_bytecnt < THRESHOLD_READ_BITS / 8)
                        reg_datao = threshold_word[reg_bytecnt*8 +: 8];
                end
                REG_STATUS: begin
                    if (reg_bytecnt < STATUS_BITS / 8)
                        reg_datao = status_word[reg_bytecnt*8 +: 8];
                end
                REG_MULTIPLE_TRIGGERS: reg_datao = reg_byte_t'(cfg.multiple_triggers);
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/sad_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module sad_sequencer import sad_pkg::*; (
    input  logic       adc_sampleclk,
    input  logic       reset,
    input  logic       armed_and_ready,
    input  logic       active,
    input  logic       xadc_error,
    sad_cfg_if.seq     cfg,
    sad_sched_if.sched sched,
    output logic       run,
    output logic       arm_edge
);

    logic      arm_meta;
    logic      arm_sync;
    logic      arm_sync_q;   // previous synchronized level, for the edge
    phase_t    phase;
    lane_vec_t start_ring;
    lane_vec_t ready_chain;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_meta <= 1'b0;
            arm_sync <= 1'b0;
            arm_sync_q <= 1'b0;
        end else begin
            arm_meta <= armed_and_ready;
            arm_sync <= arm_meta;
            arm_sync_q <= arm_sync;
        end
    end

    assign arm_edge = arm_sync & ~arm_sync_q;
    assign run = arm_sync & active & ~xadc_error;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || !run) begin
            phase <= '0;
            start_ring <= LANE_START_INIT;
            ready_chain <= '0;
        end else begin
            phase <= (phase == LAST_PHASE) ? '0 : phase + 1'b1;
            start_ring <= {start_ring[REF_SAMPLES-2:0], start_ring[REF_SAMPLES-1]};
            // lane 0 ready after the first wrap, then one more lane per cycle
            ready_chain <= {ready_chain[REF_SAMPLES-2:0], ready_chain[0] | (phase == LAST_PHASE)};
        end
    end

    assign sched.feed_sample = cfg.refsamples[phase];
    assign sched.feed_en = cfg.refen[phase];
    assign sched.lane_start = start_ring;
    assign sched.lane_ready = ready_chain;

endmodule

`default_nettype wire

/* hw/sad_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module sad_lane import sad_pkg::*; (
    input  logic    adc_sampleclk,
    input  sample_t sample,
    input  sad_t    sample_plus,   // sample zero extended, one cycle after sample
    input  sad_t    sample_minus,  // its negation
    input  sample_t ref_in,
    input  logic    en_in,
    output sample_t ref_out,
    output logic    en_out,
    input  logic    start,
    input  logic    ready,
    input  sad_t    threshold,
    output logic    match
);

    sample_t ref_q;
    sample_t ref_qq;
    logic    en_q;
    logic    en_qq;
    logic    above;       // sample greater than reference
    sad_t    incr;
    sad_t    acc;
    logic    done_q;
    logic    le_q;

    always_ff @(posedge adc_sampleclk) begin
        ref_q <= ref_in;
        en_q <= en_in;
        ref_qq <= ref_q;
        en_qq <= en_q;
        above <= sample > ref_q;
    end

    assign ref_out = ref_q;
    assign en_out = en_q;

    always_ff @(posedge adc_sampleclk) begin
        if (!en_qq)
            incr <= '0;                          // masked position
        else if (above)
            incr <= sample_plus - sad_t'(ref_qq);
        else
            incr <= sample_minus + sad_t'(ref_qq);

        // acc holds the finished window sum in the start cycle
        if (start)
            acc <= incr;
        else if (!acc[SAD_BITS-1])
            acc <= acc + incr;                   // freezes once msb sets

        done_q <= start & ready;
        le_q <= (acc <= threshold);
        match <= done_q & le_q;
    end

endmodule

`default_nettype wire

/* hw/sad_lane_array.sv */
`timescale 1ns/1ps
`default_nettype none

module sad_lane_array import sad_pkg::*; (
    input  logic       adc_sampleclk,
    input  sample_t    adc_datain,
    sad_sched_if.lanes sched,
    sad_cfg_if.lanes   cfg,
    output lane_vec_t  lane_match
);

    sample_t                adc_q;     // input capture
    sample_t                sample_r;  // fans out to every lane
    sad_t                   sample_plus;
    sad_t                   sample_minus;
    sample_t                ref_chain [REF_SAMPLES+1];
    logic [REF_SAMPLES:0]   en_chain;

    always_ff @(posedge adc_sampleclk) begin
        adc_q <= adc_datain;
        sample_r <= adc_q;
        sample_plus <= sad_t'(sample_r);
        sample_minus <= -sad_t'(sample_r);
    end

    assign ref_chain[0] = sched.feed_sample;
    assign en_chain[0] = sched.feed_en;

    for (genvar i = 0; i < REF_SAMPLES; i++) begin : g_lane
        sad_lane u_lane (
            .adc_sampleclk (adc_sampleclk),
            .sample        (sample_r),
            .sample_plus   (sample_plus),
            .sample_minus  (sample_minus),
            .ref_in        (ref_chain[i]),
            .en_in         (en_chain[i]),
            .ref_out       (ref_chain[i+1]),
            .en_out        (en_chain[i+1]),
            .start         (sched.lane_start[i]),
            .ready         (sched.lane_ready[i]),
            .threshold     (cfg.threshold),
            .match         (lane_match[i])
        );
    end

endmodule

`default_nettype wire

/* hw/sad_trigger_status.sv */
`timescale 1ns/1ps
`default_nettype none

module sad_trigger_status import sad_pkg::*; (
    input  logic                  adc_sampleclk,
    input  lane_vec_t             lane_match,
    input  logic                  run,
    input  logic                  arm_edge,
    input  logic                  clear_status,
    sad_cfg_if.status             cfg,
    output logic                  trigger,
    output logic                  triggered = 1'b0,
    output logic [COUNT_BITS-1:0] trigger_count = '0
);

    logic any_match;
    logic fire_q = 1'b0;
    logic hold_off;

    // single shot mode blocks the cycle after a pulse as well
    assign hold_off = !cfg.multiple_triggers && (triggered || trigger);

    always_ff @(posedge adc_sampleclk) begin
        any_match <= |lane_match;
        fire_q <= any_match && run && !hold_off;
    end

    assign trigger = fire_q & run;  // drops at once when disarmed

    always_ff @(posedge adc_sampleclk) begin
        if (clear_status || arm_edge) begin
            triggered <= 1'b0;
            trigger_count <= '0;
        end else if (trigger) begin
            triggered <= 1'b1;
            trigger_count <= trigger_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/sad_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sad_top import sad_pkg::*, sad_regs_pkg::*; (
    input  logic                    adc_sampleclk,
    input  logic                    reset,
    input  logic                    xadc_error,
    input  sample_t                 adc_datain,
    input  logic                    armed_and_ready,
    input  logic                    active,
    input  sad_reg_addr_e           reg_address,
    input  logic [BYTECNT_BITS-1:0] reg_bytecnt,
    input  reg_byte_t               reg_datai,
    output reg_byte_t               reg_datao,
    input  logic                    reg_read,
    input  logic                    reg_write,
    output logic                    trigger
);

    sad_cfg_if   cfg ();
    sad_sched_if sched ();

    lane_vec_t             lane_match;
    logic                  run;
    logic                  arm_edge;
    logic                  clear_status;
    logic                  triggered;
    logic [COUNT_BITS-1:0] trigger_count;

    sad_reg_bank u_reg_bank (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .reg_address   (reg_address),
        .reg_bytecnt   (reg_bytecnt),
        .reg_datai     (reg_datai),
        .reg_read      (reg_read),
        .reg_write     (reg_write),
        .reg_datao     (reg_datao),
        .triggered     (triggered),
        .trigger_count (trigger_count),
        .clear_status  (clear_status),
        .cfg           (cfg)
    );

    sad_sequencer u_sequencer (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .armed_and_ready (armed_and_ready),
        .active          (active),
        .xadc_error      (xadc_error),
        .cfg             (cfg),
        .sched           (sched),
        .run             (run),
        .arm_edge        (arm_edge)
    );

    sad_lane_array u_lane_array (
        .adc_sampleclk (adc_sampleclk),
        .adc_datain    (adc_datain),
        .sched         (sched),
        .cfg           (cfg),
        .lane_match    (lane_match)
    );

    sad_trigger_status u_trigger_status (
        .adc_sampleclk (adc_sampleclk),
        .lane_match    (lane_match),
        .run           (run),
        .arm_edge      (arm_edge),
        .clear_status  (clear_status),
        .cfg           (cfg),
        .trigger       (trigger),
        .triggered     (triggered),
        .trigger_count (trigger_count)
    );

endmodule

`default_nettype wire

/* bench/sad_props.sv */
`timescale 1ns/1ps
`default_nettype none

module sad_props import sad_pkg::*; (
    input logic                  adc_sampleclk,
    input logic                  reset,
    input logic                  active,
    input logic                  xadc_error,
    input logic                  trigger,
    input logic                  multiple_triggers,
    input logic                  clear_status,
    input logic                  arm_edge,
    input logic [COUNT_BITS-1:0] trigger_count
);

    int prop_errors = 0;   // summed into the closing line

    // inactive or faulted means no trigger
    trigger_gated: assert property (@(posedge adc_sampleclk) disable iff (reset)
        (!active || xadc_error) |-> !trigger)
        else begin
            prop_errors++;
            $error("trigger high while inactive or during xadc error");
        end

    single_pulse: assert property (@(posedge adc_sampleclk) disable iff (reset)
        (trigger && !multiple_triggers) |=> !trigger)
        else begin
            prop_errors++;
            $error("trigger held high for two cycles in single shot mode");
        end

    // count only drops through a clear
    count_monotonic: assert property (@(posedge adc_sampleclk) disable iff (reset)
        (trigger_count < $past(trigger_count)) |-> $past(clear_status || arm_edge))
        else begin
            prop_errors++;
            $error("trigger count decreased without a status write or arm");
        end

endmodule

`default_nettype wire

/* bench/sad_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sad_tb import sad_pkg::*, sad_regs_pkg::*; ();

    localparam int GAP = REF_SAMPLES + 8;          // random lead-in ahead of each window
    localparam int DRAIN = TRIGGER_LATENCY + 4;
    localparam int WARMUP = 2 * REF_SAMPLES + 16;  // sync plus lane ready fill
    localparam int PATTERN_RUNS = 12;
    localparam int WARMUPS = 2;
    localparam int REG_ACCESSES = 200;
    localparam int CYCLE_LIMIT = 2 * (PATTERN_RUNS * (GAP + REF_SAMPLES + DRAIN)
                                      + WARMUPS * (WARMUP + 8) + 2 * REG_ACCESSES) + 100;
    localparam lane_vec_t MISMATCH_POS = (lane_vec_t'(1) << 3) | (lane_vec_t'(1) << 14)
                                         | (lane_vec_t'(1) << 27);

    logic                    adc_sampleclk;
    logic                    reset;
    logic                    xadc_error;
    sample_t                 adc_datain;
    logic                    armed_and_ready;
    logic                    active;
    sad_reg_addr_e           reg_address;
    logic [BYTECNT_BITS-1:0] reg_bytecnt;
    reg_byte_t               reg_datai;
    reg_byte_t               reg_datao;
    logic                    reg_read;
    logic                    reg_write;
    logic                    trigger;

    integer  seed = 32'h4a4b_e1df;
    int      check_count = 0;
    int      error_count = 0;
    int      trigger_pulses = 0;
    int      cycle_count = 0;
    sample_t ref_pattern [REF_SAMPLES];
    sample_t mismatch [REF_SAMPLES];

    sad_top dut (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .xadc_error      (xadc_error),
        .adc_datain      (adc_datain),
        .armed_and_ready (armed_and_ready),
        .active          (active),
        .reg_address     (reg_address),
        .reg_bytecnt     (reg_bytecnt),
        .reg_datai       (reg_datai),
        .reg_datao       (reg_datao),
        .reg_read        (reg_read),
        .reg_write       (reg_write),
        .trigger         (trigger)
    );

    bind sad_top sad_props u_props (
        .adc_sampleclk     (adc_sampleclk),
        .reset             (reset),
        .active            (active),
        .xadc_error        (xadc_error),
        .trigger           (trigger),
        .multiple_triggers (cfg.multiple_triggers),
        .clear_status      (clear_status),
        .arm_edge          (arm_edge),
        .trigger_count     (trigger_count)
    );

    initial begin
        adc_sampleclk = 1'b0;
        forever #4 adc_sampleclk = ~adc_sampleclk;
    end

    // count high cycles of trigger, sampled mid cycle
    always @(negedge adc_sampleclk) begin
        if (trigger === 1'b1)
            trigger_pulses++;
    end

    always @(posedge adc_sampleclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("CHECK FAILED t=%0t %s expected=0x%0h actual=0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic write_reg(input sad_reg_addr_e addr, input int bytecnt, input reg_byte_t data);
        @(posedge adc_sampleclk);
        reg_address <= addr;
        reg_bytecnt <= bytecnt[BYTECNT_BITS-1:0];
        reg_datai <= data;
        reg_write <= 1'b1;
        @(posedge adc_sampleclk);
        reg_write <= 1'b0;
    endtask

    task automatic read_reg(input sad_reg_addr_e addr, input int bytecnt, output reg_byte_t data);
        @(posedge adc_sampleclk);
        reg_address <= addr;
        reg_bytecnt <= bytecnt[BYTECNT_BITS-1:0];
        reg_read <= 1'b1;
        @(negedge adc_sampleclk);
        data = reg_datao;
        @(posedge adc_sampleclk);
        reg_read <= 1'b0;
    endtask

    // little endian, byte 0 first
    task automatic write_word(input sad_reg_addr_e addr, input int nbytes,
                              input logic [31:0] value);
        for (int b = 0; b < nbytes; b++)
            write_reg(addr, b, value[b*8 +: 8]);
    endtask

    task automatic read_word(input sad_reg_addr_e addr, input int nbytes,
                             output logic [31:0] value);
        reg_byte_t data;
        value = '0;
        for (int b = 0; b < nbytes; b++) begin
            read_reg(addr, b, data);
            value[b*8 +: 8] = data;
        end
    endtask

    task automatic stream_sample(input sample_t s);
        @(posedge adc_sampleclk);
        adc_datain <= s;
    endtask

    task automatic stream_random(input int n);
        for (int i = 0; i < n; i++)
            stream_sample(sample_t'($random(seed)));
    endtask

    // lead-in, one window, then drain; returns trigger cycles seen meanwhile
    task automatic stream_window(input sample_t win [REF_SAMPLES], output int pulses);
        int start_pulses;
        start_pulses = trigger_pulses;
        stream_random(GAP);
        for (int i = 0; i < REF_SAMPLES; i++)
            stream_sample(win[i]);
        stream_random(DRAIN);
        pulses = trigger_pulses - start_pulses;
    endtask

    task automatic rearm;
        @(posedge adc_sampleclk);
        armed_and_ready <= 1'b0;
        repeat (4) @(posedge adc_sampleclk);
        armed_and_ready <= 1'b1;
        stream_random(WARMUP);
    endtask

    // sum of |sample - reference| over enabled positions
    function automatic int window_sad(input sample_t win [REF_SAMPLES], input lane_vec_t mask);
        int sum;
        sum = 0;
        for (int k = 0; k < REF_SAMPLES; k++) begin
            if (mask[k])
                sum += (win[k] > ref_pattern[k]) ? win[k] - ref_pattern[k]
                                                 : ref_pattern[k] - win[k];
        end
        return sum;
    endfunction

    function automatic logic [31:0] status_word(input int count, input logic trig);
        return {8'b0, count[COUNT_BITS-1:0], 7'b0, trig};
    endfunction

    initial begin
        int          pulses;
        int          sad;
        logic [31:0] value;
        reg_byte_t   data;

        reset = 1'b1;
        xadc_error = 1'b0;
        adc_datain = '0;
        armed_and_ready = 1'b0;
        active = 1'b0;
        reg_address = REG_REFERENCE;
        reg_bytecnt = '0;
        reg_datai = '0;
        reg_read = 1'b0;
        reg_write = 1'b0;
        for (int k = 0; k < REF_SAMPLES; k++)
            ref_pattern[k] = sample_t'($random(seed));
        for (int k = 0; k < REF_SAMPLES; k++)
            mismatch[k] = MISMATCH_POS[k] ? ref_pattern[k] ^ 8'h15 : ref_pattern[k];
        repeat (4) @(posedge adc_sampleclk);
        reset <= 1'b0;

        // reset values
        read_word(REG_STATUS, 3, value);
        check_value("status", 32'h0, value);
        read_word(REG_REFEN, 4, value);
        check_value("refen", 32'hffff_ffff, value);
        read_word(REG_THRESHOLD, 4, value);
        check_value("threshold", 32'h0, value);
        check_value("trigger pulses", 0, trigger_pulses);

        // register readback
        for (int k = 0; k < REF_SAMPLES; k++)
            write_reg(REG_REFERENCE, k, ref_pattern[k]);
        for (int k = 0; k < REF_SAMPLES; k++) begin
            read_reg(REG_REFERENCE, k, data);
            check_value("reference byte", ref_pattern[k], data);
        end
        write_word(REG_REFEN, 4, 32'h5a3c_96e1);
        read_word(REG_REFEN, 4, value);
        check_value("refen", 32'h5a3c_96e1, value);
        write_word(REG_REFEN, 4, 32'hffff_ffff);
        write_word(REG_THRESHOLD, 2, 32'h1234);
        write_reg(REG_THRESHOLD, 2, 8'haa);   // beyond the 16 bit threshold
        read_word(REG_THRESHOLD, 4, value);
        check_value("threshold", 32'h1234, value);
        write_reg(REG_MULTIPLE_TRIGGERS, 0, 8'h01);
        read_reg(REG_MULTIPLE_TRIGGERS, 0, data);
        check_value("multiple_triggers", 32'h1, data);
        write_reg(REG_MULTIPLE_TRIGGERS, 0, 8'h00);
        read_reg(REG_MULTIPLE_TRIGGERS, 0, data);
        check_value("multiple_triggers", 32'h0, data);

        // exact match, single shot
        write_word(REG_THRESHOLD, 2, 32'h0);
        active <= 1'b1;
        rearm();
        stream_window(ref_pattern, pulses);
        check_value("trigger pulses", 1, pulses);
        read_word(REG_STATUS, 3, value);
        check_value("status", status_word(1, 1'b1), value);
        stream_window(ref_pattern, pulses);
        check_value("trigger pulses", 0, pulses);
        read_word(REG_STATUS, 3, value);
        check_value("status", status_word(1, 1'b1), value);

        // repeated triggers
        write_reg(REG_STATUS, 0, 8'h00);
        write_reg(REG_MULTIPLE_TRIGGERS, 0, 8'h01);
        for (int n = 0; n < 3; n++) begin
            stream_window(ref_pattern, pulses);
            check_value("trigger pulses", 1, pulses);
        end
        read_word(REG_STATUS, 3, value);
        check_value("status", status_word(3, 1'b1), value);

        // threshold and enable mask
        write_reg(REG_STATUS, 0, 8'h00);
        sad = window_sad(mismatch, '1);
        stream_window(mismatch, pulses);
        check_value("trigger pulses", 0, pulses);
        write_word(REG_THRESHOLD, 2, sad - 1);
        stream_window(mismatch, pulses);
        check_value("trigger pulses", 0, pulses);
        write_word(REG_THRESHOLD, 2, sad);
        stream_window(mismatch, pulses);
        check_value("trigger pulses", 1, pulses);
        write_word(REG_THRESHOLD, 2, 32'h0);
        write_word(REG_REFEN, 4, ~MISMATCH_POS);
        stream_window(mismatch, pulses);
        check_value("trigger pulses", 1, pulses);
        write_word(REG_REFEN, 4, 32'hffff_ffff);
        read_word(REG_STATUS, 3, value);
        check_value("status", status_word(2, 1'b1), value);

        // status clear, arm clear, xadc error
        write_reg(REG_MULTIPLE_TRIGGERS, 0, 8'h00);
        write_reg(REG_STATUS, 0, 8'h00);
        read_word(REG_STATUS, 3, value);
        check_value("status", 32'h0, value);
        stream_window(ref_pattern, pulses);
        check_value("trigger pulses", 1, pulses);
        rearm();
        read_word(REG_STATUS, 3, value);
        check_value("status", 32'h0, value);
        xadc_error <= 1'b1;
        stream_window(ref_pattern, pulses);
        check_value("trigger pulses", 0, pulses);
        xadc_error <= 1'b0;
        read_word(REG_STATUS, 3, value);
        check_value("status", 32'h0, value);

        $display("checks: %0d, check errors: %0d, assertion errors: %0d",
                 check_count, error_count, dut.u_props.prop_errors);
        if (error_count == 0 && dut.u_props.prop_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
hw/sad_pkg.sv
hw/sad_regs_pkg.sv
hw/sad_cfg_if.sv
hw/sad_sched_if.sv
hw/sad_reg_bank.sv
hw/sad_sequencer.sv
hw/sad_lane.sv
hw/sad_lane_array.sv
hw/sad_trigger_status.sv
hw/sad_top.sv
bench/sad_props.sv
bench/sad_tb.sv

/* Bender.yml */
package:
  name: sad_trigger

sources:
  - hw/sad_pkg.sv
  - hw/sad_regs_pkg.sv
  - hw/sad_cfg_if.sv
  - hw/sad_sched_if.sv
  - hw/sad_reg_bank.sv
  - hw/sad_sequencer.sv
  - hw/sad_lane.sv
  - hw/sad_lane_array.sv
  - hw/sad_trigger_status.sv
  - hw/sad_top.sv
  - target: simulation
    files:
      - bench/sad_props.sv
      - bench/sad_tb.sv
